// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module line_buffer_tb -f sim.f -o line_buffer_sim || exit 1
out="$(./obj_dir/line_buffer_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim.f
src/line_buffer_pkg.sv
src/row_bank.sv
src/frame_sequencer.sv
src/column_scanner.sv
src/window_shifter.sv
src/line_buffer_top.sv
sim/line_buffer_checker.sv
sim/line_buffer_tb.sv

// File: sim/line_buffer_checker.sv
// Port assertions for the window generator and their bind to the top level
module line_buffer_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input logic                     in_ready,
    input line_buffer_pkg::pixel_t  in_pixel,
    input logic                     out_valid,
    input logic                     out_ready,
    input line_buffer_pkg::window_t out_window
);

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_window)))
        else $error("out_window or out_valid changed while out_ready was low");

    // The source keeps its pixel until the line buffer takes it
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_pixel)))
        else $error("in_pixel changed while in_ready was low");

    a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else $error("out_valid was high in the first cycle after reset");

endmodule

bind line_buffer_top line_buffer_checker u_checker (.*);

// File: sim/line_buffer_tb.sv
// Testbench for the window generator with xorshift stimulus, reference windows and timeout
module line_buffer_tb;
    import line_buffer_pkg::*;

    localparam int NUM_FRAMES  = 3;
    localparam int PASS_WINS   = LINE_WIDTH - (WIN_SIZE - 1);
    localparam int FRAME_WINS  = (FRAME_ROWS - (WIN_SIZE - 1)) * PASS_WINS;
    localparam int TOTAL_WINS  = NUM_FRAMES * FRAME_WINS;
    localparam int FRAME_PIX   = FRAME_ROWS * LINE_WIDTH;
    localparam int FRAME_COLS  = (FRAME_ROWS - (WIN_SIZE - 1)) * LINE_WIDTH;
    // Eight times the length of two frames at two cycles per pixel and per column
    localparam int CYCLE_LIMIT = 8 * 2 * (2 * FRAME_PIX + 2 * FRAME_COLS);

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    pixel_t      in_pixel;
    logic        out_valid;
    logic        out_ready;
    window_t     out_window;
    logic        ready_random;
    logic [31:0] gap_rng;
    logic [31:0] rdy_rng;
    pixel_t      frame_pix [NUM_FRAMES][FRAME_ROWS][LINE_WIDTH];
    int          cycles    = 0;
    int          win_count = 0;
    int          pix_count = 0;

    line_buffer_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_pixel   (in_pixel),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_window (out_window)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Column c of rows p to p+3, oldest row first
    function automatic win_col_t ref_column(input int f, input int p, input int c);
        win_col_t col;
        col.row0 = frame_pix[f][p][c];
        col.row1 = frame_pix[f][p+1][c];
        col.row2 = frame_pix[f][p+2][c];
        col.row3 = frame_pix[f][p+3][c];
        return col;
    endfunction

    function automatic window_t ref_window(input int f, input int p, input int c);
        window_t w;
        w.col0 = ref_column(f, p, c - 3);
        w.col1 = ref_column(f, p, c - 2);
        w.col2 = ref_column(f, p, c - 1);
        w.col3 = ref_column(f, p, c);
        return w;
    endfunction

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_window(input string name, input window_t got, input window_t exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input string name, input integer got, input integer exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail time=%0t %s got=%b expected=%b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // Holds the pixel until in_ready is seen, with optional idle cycles before it
    task automatic send_pixel(input pixel_t pix, input logic gaps);
        @(negedge clk);
        if (gaps) begin
            gap_rng = xorshift32(gap_rng);
            while (gap_rng[2:1] == 2'b00) begin
                in_valid = 1'b0;
                @(negedge clk);
                gap_rng = xorshift32(gap_rng);
            end
        end
        in_valid = 1'b1;
        in_pixel = pix;
        while (!in_ready) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        rdy_rng   = xorshift32(rdy_rng);
        out_ready = ready_random ? rdy_rng[7] : 1'b1;
    end

    always @(posedge clk) begin : compare
        int f;
        int p;
        int c;
        int idx;
        if (rst_n && in_valid && in_ready) begin
            pix_count = pix_count + 1;
        end
        if (rst_n && out_valid && out_ready) begin
            idx = win_count % FRAME_WINS;
            f = win_count / FRAME_WINS;
            p = idx / PASS_WINS;
            c = (WIN_SIZE - 1) + idx % PASS_WINS;
            win_count = win_count + 1;
            if (f >= NUM_FRAMES) begin
                $display("A window came out after all frames were complete");
                stop_with_failure();
            end else if (pix_count < f * FRAME_PIX + (p + WIN_SIZE) * LINE_WIDTH) begin
                $display("Window %0d came out before its four rows were sent", win_count - 1);
                stop_with_failure();
            end else begin
                check_window("out_window", out_window, ref_window(f, p, c));
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d windows received", cycles, win_count);
            stop_with_failure();
        end
    end

    initial begin
        logic [31:0] rng;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_pixel     = '0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        rng          = 32'd84765;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int r = 0; r < FRAME_ROWS; r++) begin
                for (int c = 0; c < LINE_WIDTH; c++) begin
                    rng = xorshift32(rng);
                    frame_pix[f][r][c] = rng[PIXEL_W-1:0];
                end
            end
        end
        gap_rng = xorshift32(rng ^ 32'h9e3779b9);
        rdy_rng = xorshift32(gap_rng ^ 32'h7f4a7c15);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        // Frame 0 runs freely, frame 1 sees output stalls, frame 2 adds input gaps
        for (int f = 0; f < NUM_FRAMES; f++) begin
            ready_random = (f >= 1);
            for (int r = 0; r < FRAME_ROWS; r++) begin
                for (int c = 0; c < LINE_WIDTH; c++) begin
                    send_pixel(frame_pix[f][r][c], f == 2);
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        // The sequencer takes input again once the last pass of the frame is over
        wait (in_ready);
        ready_random = 1'b0;
        repeat (4 * LINE_WIDTH) @(negedge clk);
        check_count("win_count", win_count, TOTAL_WINS);
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: src/column_scanner.sv
// Read column counter issuing bank reads and ordering bank data into a window column
module column_scanner (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       pass_start,
    input  line_buffer_pkg::bank_idx_t oldest_bank,
    input  logic                       accept_col,
    input  line_buffer_pkg::pixel_t    bank_data [line_buffer_pkg::NUM_BANKS],
    output logic                       rd_en,
    output line_buffer_pkg::col_addr_t rd_addr,
    output logic                       col_valid,
    output line_buffer_pkg::win_col_t  col_data,
    output logic                       pass_done
);
    import line_buffer_pkg::*;

    logic active;

    // Pending read is the one whose data is on col_valid this cycle
    assign rd_en = active && accept_col && !col_valid;

    always_comb begin
        col_data.row0 = bank_data[bank_add(oldest_bank, 0)];
        col_data.row1 = bank_data[bank_add(oldest_bank, 1)];
        col_data.row2 = bank_data[bank_add(oldest_bank, 2)];
        col_data.row3 = bank_data[bank_add(oldest_bank, 3)];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            rd_addr   <= '0;
            col_valid <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            col_valid <= rd_en;
            pass_done <= rd_en && (rd_addr == LAST_COL);    // Arrives with the last column
            if (pass_start) begin
                active  <= 1'b1;
                rd_addr <= '0;
            end else if (rd_en) begin
                if (rd_addr == LAST_COL) begin
                    active  <= 1'b0;
                    rd_addr <= '0;
                end else begin
                    rd_addr <= rd_addr + col_addr_t'(1);
                end
            end
        end
    end

endmodule

// File: src/frame_sequencer.sv
// Fill and run FSM with bank rotation, write column, input ready and per-bank control
module frame_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic                        pass_done,
    input  logic                        rd_en,
    input  line_buffer_pkg::col_addr_t  rd_addr,
    output logic                        pass_start,
    output line_buffer_pkg::bank_idx_t  oldest_bank,
    output line_buffer_pkg::bank_ctrl_t bank_ctrl [line_buffer_pkg::NUM_BANKS]
);
    import line_buffer_pkg::*;

    seq_state_t state;
    col_addr_t  wr_col;
    row_cnt_t   rows_written;
    bank_idx_t  wr_bank;
    logic       done_seen;
    logic       spare_full;
    logic       wr_fire;
    logic       row_done;
    logic       last_pass;
    logic       pass_end;

    assign wr_fire  = in_valid && in_ready;
    assign row_done = wr_fire && (wr_col == LAST_COL);

    // A pass with no spare row left to write is the last one of the frame
    assign last_pass = (rows_written == ALL_ROWS) && !spare_full;
    assign pass_end  = (state == RUN) && (pass_done || done_seen)
                       && (spare_full || row_done || last_pass);

    assign in_ready = (state == FILL) ? 1'b1 : (!spare_full && (rows_written != ALL_ROWS));

    always_comb begin
        if (state == FILL) begin
            wr_bank = bank_add(oldest_bank, int'(rows_written));
        end else begin
            wr_bank = bank_add(oldest_bank, WIN_SIZE);    // The spare bank
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (bank_idx_t'(b) == wr_bank) begin
                bank_ctrl[b].cs   = wr_fire;
                bank_ctrl[b].we   = 1'b1;
                bank_ctrl[b].addr = wr_col;
            end else begin
                bank_ctrl[b].cs   = rd_en;
                bank_ctrl[b].we   = 1'b0;
                bank_ctrl[b].addr = rd_addr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= FILL;
            wr_col       <= '0;
            rows_written <= '0;
            oldest_bank  <= '0;
            done_seen    <= 1'b0;
            spare_full   <= 1'b0;
            pass_start   <= 1'b0;
        end else begin
            pass_start <= 1'b0;
            if (wr_fire) begin
                wr_col <= (wr_col == LAST_COL) ? '0 : wr_col + col_addr_t'(1);
            end
            if (row_done) begin
                rows_written <= rows_written + row_cnt_t'(1);
            end
            case (state)
                FILL: begin
                    if (row_done && (rows_written == LAST_FILL_ROW)) begin
                        state      <= RUN;
                        pass_start <= 1'b1;
                    end
                end
                RUN: begin
                    if (pass_end) begin
                        done_seen  <= 1'b0;
                        spare_full <= 1'b0;
                        if (last_pass) begin
                            state        <= FILL;
                            rows_written <= '0;
                            oldest_bank  <= '0;
                        end else begin
                            pass_start  <= 1'b1;
                            oldest_bank <= bank_add(oldest_bank, 1);    // Oldest row drops out
                        end
                    end else begin
                        if (pass_done) begin
                            done_seen <= 1'b1;
                        end
                        if (row_done) begin
                            spare_full <= 1'b1;
                        end
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

endmodule

// File: src/line_buffer_pkg.sv
// Sizes, pixel and address types, bank control and window structs, sequencer states
package line_buffer_pkg;

    localparam int LINE_WIDTH = 8;
    localparam int FRAME_ROWS = 8;
    localparam int NUM_BANKS  = 5;
    localparam int WIN_SIZE   = 4;
    localparam int PIXEL_W    = 24;

    localparam int COL_W     = $clog2(LINE_WIDTH);
    localparam int BANK_W    = $clog2(NUM_BANKS);
    localparam int ROW_W     = $clog2(FRAME_ROWS + 1);
    localparam int WIN_CNT_W = $clog2(WIN_SIZE);

    typedef logic [PIXEL_W-1:0] pixel_t;    // Packed RGB, 8 bits per channel
    typedef logic [COL_W-1:0]   col_addr_t;
    typedef logic [BANK_W-1:0]  bank_idx_t;
    typedef logic [ROW_W-1:0]   row_cnt_t;

    localparam col_addr_t LAST_COL      = col_addr_t'(LINE_WIDTH - 1);
    localparam row_cnt_t  LAST_FILL_ROW = row_cnt_t'(WIN_SIZE - 1);
    localparam row_cnt_t  ALL_ROWS      = row_cnt_t'(FRAME_ROWS);

    typedef struct packed {
        logic      cs;
        logic      we;
        col_addr_t addr;
    } bank_ctrl_t;

    typedef struct packed {
        pixel_t row0;    // Oldest row of the pass
        pixel_t row1;
        pixel_t row2;
        pixel_t row3;
    } win_col_t;

    typedef struct packed {
        win_col_t col0;    // Leftmost column
        win_col_t col1;
        win_col_t col2;
        win_col_t col3;
    } window_t;

    typedef enum logic {
        FILL,
        RUN
    } seq_state_t;

    // Bank index base+offset modulo NUM_BANKS, valid for offset below NUM_BANKS
    function automatic bank_idx_t bank_add(bank_idx_t base, int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= NUM_BANKS) begin
            sum = sum - NUM_BANKS;
        end
        return bank_idx_t'(sum);
    endfunction

endpackage

// File: src/line_buffer_top.sv
// Window generator top with sequencer, scanner, shifter and five row banks
module line_buffer_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  line_buffer_pkg::pixel_t  in_pixel,
    output logic                     out_valid,
    input  logic                     out_ready,
    output line_buffer_pkg::window_t out_window
);
    import line_buffer_pkg::*;

    logic       pass_start;
    logic       pass_done;
    logic       rd_en;
    logic       col_valid;
    logic       accept_col;
    bank_idx_t  oldest_bank;
    col_addr_t  rd_addr;
    win_col_t   col_data;
    bank_ctrl_t bank_ctrl [NUM_BANKS];
    pixel_t     bank_data [NUM_BANKS];

    frame_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pass_done   (pass_done),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .pass_start  (pass_start),
        .oldest_bank (oldest_bank),
        .bank_ctrl   (bank_ctrl)
    );

    column_scanner u_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .pass_start  (pass_start),
        .oldest_bank (oldest_bank),
        .accept_col  (accept_col),
        .bank_data   (bank_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .col_valid   (col_valid),
        .col_data    (col_data),
        .pass_done   (pass_done)
    );

    window_shifter u_shifter (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_valid  (col_valid),
        .col_data   (col_data),
        .pass_start (pass_start),
        .accept_col (accept_col),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_window (out_window)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        row_bank u_bank (
            .clk     (clk),
            .ctrl    (bank_ctrl[b]),
            .wr_data (in_pixel),    // All banks see the input, only the write bank selects it
            .rd_data (bank_data[b])
        );
    end

endmodule

// File: src/row_bank.sv
// Single row memory with synchronous write and registered read
module row_bank (
    input  logic                        clk,
    input  line_buffer_pkg::bank_ctrl_t ctrl,
    input  line_buffer_pkg::pixel_t     wr_data,
    output line_buffer_pkg::pixel_t     rd_data
);
    import line_buffer_pkg::*;

    pixel_t mem [LINE_WIDTH];

    always_ff @(posedge clk) begin
        if (ctrl.cs) begin
            if (ctrl.we) begin
                mem[ctrl.addr] <= wr_data;
            end else begin
                rd_data <= mem[ctrl.addr];    // Data shows up the cycle after the select
            end
        end
    end

endmodule

// File: src/window_shifter.sv
// Four-column window shift register with a held valid/ready output
module window_shifter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      col_valid,
    input  line_buffer_pkg::win_col_t col_data,
    input  logic                      pass_start,
    output logic                      accept_col,
    output logic                      out_valid,
    input  logic                      out_ready,
    output line_buffer_pkg::window_t  out_window
);
    import line_buffer_pkg::*;

    win_col_t             hist [WIN_SIZE-1];    // Previous columns, oldest first
    logic [WIN_CNT_W-1:0] col_cnt;
    logic                 full;

    assign full       = (col_cnt == WIN_CNT_W'(WIN_SIZE - 1));
    assign accept_col = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (pass_start) begin
                col_cnt <= '0;
            end else if (col_valid && !full) begin
                col_cnt <= col_cnt + 1'b1;
            end
            if (col_valid && full) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // A column only arrives once the previous window has left
    always_ff @(posedge clk) begin
        if (col_valid) begin
            for (int k = 0; k < WIN_SIZE - 2; k++) begin
                hist[k] <= hist[k+1];
            end
            hist[WIN_SIZE-2] <= col_data;
            if (full) begin
                out_window <= '{col0: hist[0], col1: hist[1], col2: hist[2], col3: col_data};
            end
        end
    end

endmodule
